/* build.f */
+incdir+include
verilog/platformPkg.sv
verilog/platLink.sv
verilog/platformGenerator.sv
verilog/platformTable.sv
verilog/pixelRenderer.sv
verilog/colorMapper.sv
testbench/colorMapperTb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module colorMapperTb \
    -f build.f --Mdir obj_dir -o colorMapperSim

# status of tee only, the log decides the result
./obj_dir/colorMapperSim 2>&1 | tee sim.log

if grep -q "^Testbench passed$" sim.log; then
    echo "simulation ok"
    exit 0
else
    echo "simulation did not pass, see sim.log"
    exit 1
fi

/* include/colorMapperModel.svh */
`ifndef COLOR_MAPPER_MODEL_SVH
`define COLOR_MAPPER_MODEL_SVH

// one lfsr step shifting left with feedback from bits 8 and 4
function automatic logic [PlatW-1:0] nextLfsr(input logic [PlatW-1:0] v);
    logic fb;
    fb = v[8] ^ v[4];
    return (v << 1) | PlatW'(fb);
endfunction

function automatic logic [PlatW-1:0] loadX(input int k);
    logic [PlatW-1:0] raw;
    int r;
    raw = LfsrSeed;
    for (int i = 0; i < k; i++)
        raw = nextLfsr(raw);
    r = int'(raw);
    if (r <= int'(XShiftLimit))
        r = r + int'(XOffset);
    return PlatW'(r);
endfunction

// load height minus everything scrolled so far modulo 512
function automatic logic [PlatW-1:0] scrolledY(input int k, input int unsigned scrollSum);
    return PlatW'(int'(PlatSpacing) * (k + 1) - scrollSum);
endfunction

function automatic int halfWidthOf(input difficultyT d);
    case (d)
        DiffEasy:   return int'(HalfEasy);
        DiffMedium: return int'(HalfMedium);
        default:    return int'(HalfHard);
    endcase
endfunction

function automatic bit insideBox(input int px, input int py, input int cx, input int cy,
                                 input int hx, input int hy);
    int dx;
    int dy;
    dx = (px >= cx) ? px - cx : cx - px;
    dy = (py >= cy) ? py - cy : cy - py;
    return (dx <= hx) && (dy <= hy);
endfunction

// expected color once all slots are loaded
function automatic rgbT colorAt(input int drawX, input int drawY, input int doodleX,
                                input int doodleY, input int doodleSize,
                                input difficultyT d, input int unsigned scrollSum);
    bit platHit;
    platHit = 1'b0;
    if (insideBox(drawX, drawY, doodleX, doodleY, doodleSize, doodleSize))
        return DoodleColor;
    for (int k = 0; k < NumPlats; k++)
    begin
        if (insideBox(drawX, drawY, int'(loadX(k)), int'(scrolledY(k, scrollSum)),
                      halfWidthOf(d), int'(PlatHalfY)))
            platHit = 1'b1;
    end
    return platHit ? PlatColor : BackColor;
endfunction

`endif

/* testbench/colorMapperTb.sv */
`timescale 1ns/1ps
`default_nettype none

module colorMapperTb
    import platformPkg::*;
();
    `include "colorMapperModel.svh"

    localparam int NumTicks = 6;
    localparam int NumRandPixels = 64;
    localparam int TotalPixels = 4 * 2 * NumPlats + NumPlats + 25 + NumRandPixels;
    localparam int WatchdogCycles = (NumPlats * 10 + TotalPixels + NumTicks) * 2;

    logic Clk;
    logic loadplat;
    logic FrameTick;
    logic PixelValid;
    logic [PlatW-1:0] ScrollStep;
    logic [1:0] Difficulty;
    logic [CoordW-1:0] DrawX;
    logic [CoordW-1:0] DrawY;
    logic [CoordW-1:0] DoodleX;
    logic [CoordW-1:0] DoodleY;
    logic [CoordW-1:0] DoodleSize;
    logic FillDone;
    logic RgbValid;
    logic [7:0] Red;
    logic [7:0] Green;
    logic [7:0] Blue;

    rgbT gotPixel;
    rgbT expQ [$];
    int expCycle [$];
    int cycle = 0;
    int unsigned scrollSum = 0;
    integer seed;
    bit fillSeen = 1'b0;

    assign gotPixel = {Red, Green, Blue};

    colorMapper dut0 (
        .Clk        (Clk),
        .loadplat   (loadplat),
        .FrameTick  (FrameTick),
        .PixelValid (PixelValid),
        .ScrollStep (ScrollStep),
        .Difficulty (Difficulty),
        .DrawX      (DrawX),
        .DrawY      (DrawY),
        .DoodleX    (DoodleX),
        .DoodleY    (DoodleY),
        .DoodleSize (DoodleSize),
        .FillDone   (FillDone),
        .RgbValid   (RgbValid),
        .Red        (Red),
        .Green      (Green),
        .Blue       (Blue)
    );

    initial
    begin
        Clk = 1'b0;
        forever #10 Clk = ~Clk;
    end

    always @(posedge Clk)
        cycle <= cycle + 1;

    // --------------------
    // failure reporting and checks
    task automatic stopWithFail(input string why);
        $display("%s", why);
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic checkRgb(input string name, input rgbT got, input rgbT exp);
        if (got !== exp)
            stopWithFail($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
    endtask

    task automatic checkFlag(input string name, input logic got, input logic exp);
        if (got !== exp)
            stopWithFail($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
    endtask

    // one pixel per call with its result due on the next edge
    task automatic sendPixel(input int x, input int y);
        DrawX = CoordW'(x);
        DrawY = CoordW'(y);
        PixelValid = 1'b1;
        expQ.push_back(colorAt(int'(DrawX), int'(DrawY), int'(DoodleX), int'(DoodleY),
                               int'(DoodleSize), difficultyT'(Difficulty), scrollSum));
        expCycle.push_back(cycle + 1);
        @(posedge Clk);
        #2;
    endtask

    // --------------------
    // compare process sampling mid-cycle
    always @(negedge Clk)
    begin
        if (!loadplat)
        begin
            if (fillSeen)
                checkFlag("FillDone", FillDone, 1'b1);
            if (RgbValid)
            begin
                if (expQ.size() == 0)
                    stopWithFail("RgbValid went high with no pixel outstanding");
                if (expCycle.pop_front() != cycle)
                    stopWithFail("a pixel result arrived on the wrong cycle");
                checkRgb("Pixel", gotPixel, expQ.pop_front());
            end
            else if (expCycle.size() != 0 && expCycle[0] <= cycle)
                stopWithFail("a pixel result did not arrive one cycle after its request");
        end
    end

    initial
    begin
        repeat (WatchdogCycles) @(posedge Clk);
        stopWithFail("watchdog expired before the tests finished");
    end

    initial
    begin : stimulus
        int k;
        int s;
        int cx;
        int cy;
        int offs [5];
        seed = 69;
        loadplat = 1'b1;
        FrameTick = 1'b0;
        PixelValid = 1'b0;
        ScrollStep = '0;
        Difficulty = 2'(DiffEasy);
        DrawX = '0;
        DrawY = '0;
        DoodleX = '1;
        DoodleY = '1;
        DoodleSize = '0;
        repeat (4) @(posedge Clk);
        #2;
        loadplat = 1'b0;
        checkFlag("FillDone", FillDone, 1'b0);
        checkFlag("RgbValid", RgbValid, 1'b0);

        // wait for the fill
        while (FillDone !== 1'b1)
        begin
            @(posedge Clk);
            #2;
        end
        fillSeen = 1'b1;

        // centers and just past the half width with the doodle off screen
        for (int d = 0; d < 4; d++)
        begin
            Difficulty = 2'(d);
            for (int p = 0; p < NumPlats; p++)
            begin
                cx = int'(loadX(p));
                cy = int'(scrolledY(p, scrollSum));
                sendPixel(cx, cy);
                sendPixel(cx + halfWidthOf(difficultyT'(Difficulty)) + 1, cy);
            end
        end
        PixelValid = 1'b0;

        // --------------------
        // scrolling
        repeat (NumTicks)
        begin
            ScrollStep = PlatW'($random(seed));
            FrameTick = 1'b1;
            scrollSum = scrollSum + int'(ScrollStep);
            @(posedge Clk);
            #2;
            FrameTick = 1'b0;
        end
        Difficulty = 2'(DiffMedium);
        for (int p = 0; p < NumPlats; p++)
            sendPixel(int'(loadX(p)), int'(scrolledY(p, scrollSum)));

        // doodle box on top of a platform including its edges
        k = 0;
        while (k < NumPlats - 1 && int'(scrolledY(k, scrollSum)) < 32)
            k++;
        s = 1 + ($unsigned($random(seed)) % 15);
        Difficulty = 2'(DiffEasy);
        DoodleSize = CoordW'(s);
        DoodleX = CoordW'(loadX(k));
        DoodleY = CoordW'(scrolledY(k, scrollSum));
        offs = '{-s - 1, -s, 0, s, s + 1};
        for (int i = 0; i < 5; i++)
        begin
            for (int j = 0; j < 5; j++)
                sendPixel(int'(DoodleX) + offs[i], int'(DoodleY) + offs[j]);
        end

        // back to back random pixels near platforms
        repeat (NumRandPixels)
        begin
            k = $unsigned($random(seed)) % NumPlats;
            Difficulty = 2'($random(seed));
            DoodleSize = CoordW'($unsigned($random(seed)) % 32);
            cx = int'(loadX(k)) + ($random(seed) % 40);
            cy = int'(scrolledY(k, scrollSum)) + ($random(seed) % 12);
            sendPixel(cx, cy);
        end
        PixelValid = 1'b0;

        while (expQ.size() != 0)
        begin
            @(posedge Clk);
            #2;
        end
        @(posedge Clk);
        #2;
        $display("Testbench passed");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/colorMapper.sv */
`timescale 1ns/1ps
`default_nettype none

module colorMapper
    import platformPkg::*;
(
    input  logic Clk,
    input  logic loadplat,
    input  logic FrameTick,
    input  logic PixelValid,
    input  logic [PlatW-1:0] ScrollStep,
    input  logic [1:0] Difficulty,
    input  logic [CoordW-1:0] DrawX,
    input  logic [CoordW-1:0] DrawY,
    input  logic [CoordW-1:0] DoodleX,
    input  logic [CoordW-1:0] DoodleY,
    input  logic [CoordW-1:0] DoodleSize,
    output logic FillDone,
    output logic RgbValid,
    output logic [7:0] Red,
    output logic [7:0] Green,
    output logic [7:0] Blue
);
    platArrayT platforms;
    rgbT pixel;

    platLink link0 ();

    // --------------------
    // fill path from generator into table
    platformGenerator gen0 (
        .Clk      (Clk),
        .loadplat (loadplat),
        .Link     (link0.producer),
        .FillDone (FillDone)
    );

    platformTable table0 (
        .Clk        (Clk),
        .loadplat   (loadplat),
        .Link       (link0.buffer),
        .FrameTick  (FrameTick),
        .ScrollStep (ScrollStep),
        .Platforms  (platforms)
    );

    // --------------------
    // pixel path
    pixelRenderer render0 (
        .Clk        (Clk),
        .loadplat   (loadplat),
        .PixelValid (PixelValid),
        .DrawX      (DrawX),
        .DrawY      (DrawY),
        .DoodleX    (DoodleX),
        .DoodleY    (DoodleY),
        .DoodleSize (DoodleSize),
        .Difficulty (difficultyT'(Difficulty)),
        .Platforms  (platforms),
        .RgbValid   (RgbValid),
        .Pixel      (pixel)
    );

    assign Red = pixel.red;
    assign Green = pixel.green;
    assign Blue = pixel.blue;

endmodule

`default_nettype wire

/* verilog/pixelRenderer.sv */
`timescale 1ns/1ps
`default_nettype none

module pixelRenderer
    import platformPkg::*;
(
    input  logic Clk,
    input  logic loadplat,
    input  logic PixelValid,
    input  logic [CoordW-1:0] DrawX,
    input  logic [CoordW-1:0] DrawY,
    input  logic [CoordW-1:0] DoodleX,
    input  logic [CoordW-1:0] DoodleY,
    input  logic [CoordW-1:0] DoodleSize,
    input  difficultyT Difficulty,
    input  platArrayT Platforms,
    output logic RgbValid,
    output rgbT Pixel
);
    logic [CoordW-1:0] halfX;
    logic doodleHit;
    logic platHit;
    rgbT color;

    // box test on absolute distance with one extra bit for the sign
    function automatic logic inBox(
        input logic [CoordW-1:0] px,
        input logic [CoordW-1:0] py,
        input logic [CoordW-1:0] cx,
        input logic [CoordW-1:0] cy,
        input logic [CoordW-1:0] hx,
        input logic [CoordW-1:0] hy
    );
        logic [CoordW:0] dx;
        logic [CoordW:0] dy;
        dx = {1'b0, px} - {1'b0, cx};
        dy = {1'b0, py} - {1'b0, cy};
        if (dx[CoordW])
            dx = -dx;
        if (dy[CoordW])
            dy = -dy;
        return (dx <= {1'b0, hx}) && (dy <= {1'b0, hy});
    endfunction

    // narrower platforms on harder settings
    always_comb
    begin
        unique case (Difficulty)
            DiffEasy:   halfX = HalfEasy;
            DiffMedium: halfX = HalfMedium;
            default:    halfX = HalfHard;
        endcase
    end

    assign doodleHit = inBox(DrawX, DrawY, DoodleX, DoodleY, DoodleSize, DoodleSize);

    always_comb
    begin
        platHit = 1'b0;
        for (int i = 0; i < NumPlats; i++)
        begin
            if (Platforms[i].valid && inBox(DrawX, DrawY, CoordW'(Platforms[i].x),
                                            CoordW'(Platforms[i].y), halfX, PlatHalfY))
                platHit = 1'b1;
        end
    end

    // doodle over platform over background
    assign color = doodleHit ? DoodleColor : (platHit ? PlatColor : BackColor);

    always_ff @(posedge Clk or posedge loadplat)
    begin
        if (loadplat)
            RgbValid <= 1'b0;
        else
            RgbValid <= PixelValid;
    end

    always_ff @(posedge Clk)
    begin
        if (PixelValid)
            Pixel <= color;
    end

    pixelKnown: assert property (@(posedge Clk) disable iff (loadplat)
        RgbValid |-> !$isunknown(Pixel));

endmodule

`default_nettype wire

/* verilog/platLink.sv */
`timescale 1ns/1ps
`default_nettype none

// four-phase req/ack link carrying one platform slot per handshake
interface platLink
    import platformPkg::*;
();
    logic Req;
    logic Ack;
    logic [SlotW-1:0] Slot;
    logic [PlatW-1:0] PosX;

    modport producer (
        output Req,
        output Slot,
        output PosX,
        input  Ack
    );

    modport buffer (
        input  Req,
        input  Slot,
        input  PosX,
        output Ack
    );
endinterface

`default_nettype wire

/* verilog/platformGenerator.sv */
`timescale 1ns/1ps
`default_nettype none

module platformGenerator
    import platformPkg::*;
(
    input  logic Clk,
    input  logic loadplat,
    platLink.producer Link,
    output logic FillDone
);
    genStateT state;
    logic [PlatW-1:0] lfsr;
    logic [SlotW-1:0] slot;
    logic req;

    // small raw values get pushed away from the left edge
    assign Link.PosX = (lfsr <= XShiftLimit) ? lfsr + XOffset : lfsr;
    assign Link.Slot = slot;
    assign Link.Req = req;

    always_ff @(posedge Clk or posedge loadplat)
    begin
        if (loadplat)
        begin
            state <= GenRequest;
            lfsr <= LfsrSeed;
            slot <= '0;
            req <= 1'b0;
            FillDone <= 1'b0;
        end
        else
        begin
            unique case (state)
                GenRequest:
                begin
                    // hold req until the table answers
                    if (Link.Ack)
                    begin
                        req <= 1'b0;
                        state <= GenRelease;
                    end
                    else
                        req <= 1'b1;
                end
                GenRelease:
                begin
                    if (!Link.Ack)
                    begin
                        // one lfsr step per finished handshake
                        lfsr <= {lfsr[PlatW-2:0], lfsr[8] ^ lfsr[4]};
                        if (slot == SlotW'(NumPlats - 1))
                        begin
                            FillDone <= 1'b1;
                            state <= GenDone;
                        end
                        else
                        begin
                            slot <= slot + 1'b1;
                            req <= 1'b1;
                            state <= GenRequest;
                        end
                    end
                end
                // park here once all slots are loaded
                default: FillDone <= 1'b1;
            endcase
        end
    end

    reqHeldUntilAck: assert property (@(posedge Clk) disable iff (loadplat)
        $fell(Link.Req) |-> $past(Link.Ack && state == GenRequest));

endmodule

`default_nettype wire

/* verilog/platformPkg.sv */
`default_nettype none

package platformPkg;

    // --------------------
    // widths and counts
    localparam int CoordW = 10;
    localparam int PlatW = 9;
    localparam int NumPlats = 16;
    localparam int SlotW = 4;

    // placement
    localparam logic [PlatW-1:0] LfsrSeed = 9'h1AB;
    localparam logic [PlatW-1:0] XShiftLimit = 9'd400;
    localparam logic [PlatW-1:0] XOffset = 9'd100;
    localparam logic [PlatW-1:0] PlatSpacing = 9'd28;

    // half sizes of the platform box
    localparam logic [CoordW-1:0] PlatHalfY = 10'd4;
    localparam logic [CoordW-1:0] HalfEasy = 10'd32;
    localparam logic [CoordW-1:0] HalfMedium = 10'd16;
    localparam logic [CoordW-1:0] HalfHard = 10'd8;

    // --------------------
    // types
    typedef enum logic [1:0] {
        DiffEasy = 2'd0,
        DiffMedium = 2'd1,
        DiffHard = 2'd2
    } difficultyT;

    typedef enum logic [1:0] {
        GenRequest,
        GenRelease,
        GenDone
    } genStateT;

    typedef struct packed {
        logic valid;
        logic [PlatW-1:0] x;
        logic [PlatW-1:0] y;
    } platformT;

    typedef platformT [NumPlats-1:0] platArrayT;

    typedef struct packed {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } rgbT;

    // colors
    localparam rgbT DoodleColor = 24'hA5A525;
    localparam rgbT PlatColor = 24'h66DD11;
    localparam rgbT BackColor = 24'hEDE2D4;

endpackage

`default_nettype wire

/* verilog/platformTable.sv */
`timescale 1ns/1ps
`default_nettype none

module platformTable
    import platformPkg::*;
(
    input  logic Clk,
    input  logic loadplat,
    platLink.buffer Link,
    input  logic FrameTick,
    input  logic [PlatW-1:0] ScrollStep,
    output platArrayT Platforms
);
    logic [NumPlats-1:0] validQ;
    logic [PlatW-1:0] xQ [NumPlats];
    logic [PlatW-1:0] yQ [NumPlats];
    logic ack;
    logic writeEn;
    logic [PlatW-1:0] loadY;

    assign Link.Ack = ack;

    // the scroll owns the cycle, so a write waits out a frame tick
    assign writeEn = Link.Req && !ack && !FrameTick;

    // slot 0 sits one spacing below the top
    assign loadY = PlatSpacing * ({{(PlatW - SlotW){1'b0}}, Link.Slot} + 1'b1);

    // --------------------
    // handshake and valid bits
    always_ff @(posedge Clk or posedge loadplat)
    begin
        if (loadplat)
        begin
            ack <= 1'b0;
            validQ <= '0;
        end
        else if (writeEn)
        begin
            ack <= 1'b1;
            validQ[Link.Slot] <= 1'b1;
        end
        else if (!Link.Req && ack)
        begin
            ack <= 1'b0;
        end
    end

    // --------------------
    // positions
    always_ff @(posedge Clk)
    begin
        if (FrameTick)
        begin
            // upward scroll wrapping at 512
            for (int i = 0; i < NumPlats; i++)
            begin
                if (validQ[i])
                    yQ[i] <= yQ[i] - ScrollStep;
            end
        end
        else if (writeEn)
        begin
            xQ[Link.Slot] <= Link.PosX;
            yQ[Link.Slot] <= loadY;
        end
    end

    always_comb
    begin
        for (int i = 0; i < NumPlats; i++)
        begin
            Platforms[i].valid = validQ[i];
            Platforms[i].x = xQ[i];
            Platforms[i].y = yQ[i];
        end
    end

    ackRiseWithReq: assert property (@(posedge Clk) disable iff (loadplat)
        $rose(Link.Ack) |-> Link.Req);

    ackFallAfterReq: assert property (@(posedge Clk) disable iff (loadplat)
        $fell(Link.Ack) |-> $past(!Link.Req));

endmodule

`default_nettype wire
